// File: source/dma_pkg.sv
`default_nettype none

//////////////////////////////////////////////////
// channel level types and widths
//////////////////////////////////////////////////

package dma_pkg;

  localparam int unsigned num_channels = 4;   // fixed by the register map
  localparam int unsigned addr_width   = 64;
  localparam int unsigned len_width    = 32;
  localparam int unsigned total_width  = 48;  // length totals wrap at 256 TB
  localparam int unsigned count_width  = 32;  // counters and status words

  // user command, single cycle strobe
  typedef struct packed {
    logic                  valid;
    logic [addr_width-1:0] addr;
    logic [len_width-1:0]  len;
  } dma_cmd_t;

  // descriptor bypass load towards the engine
  typedef struct packed {
    logic                  load;  // one cycle
    logic [addr_width-1:0] addr;  // held until next load
    logic [len_width-1:0]  len;
  } dma_dsc_t;

  // data beat strobe, payload not needed for stats
  typedef struct packed {
    logic valid;
    logic last;   // end of packet
  } dma_beat_t;

  // clear pulses for one channel
  typedef struct packed {
    logic clear_wr_len;
    logic clear_rd_len;
  } chan_clear_t;

endpackage

`default_nettype wire

// File: source/dma_regs_pkg.sv
`default_nettype none

package dma_regs_pkg;

  //////////////////////////////////////////////////
  // host port
  //////////////////////////////////////////////////
  localparam int unsigned reg_addr_width = 9;   // 512 words
  localparam int unsigned reg_data_width = 32;

  typedef struct packed {
    logic                      strobe;
    logic [reg_addr_width-1:0] addr;
    logic [reg_data_width-1:0] data;
  } reg_wr_t;

  typedef struct packed {
    logic                      strobe;
    logic [reg_addr_width-1:0] addr;
  } reg_rd_t;

  //////////////////////////////////////////////////
  // register map
  //////////////////////////////////////////////////
  localparam int unsigned version_addr  = 0;
  localparam int unsigned scratch_addr  = 1;
  localparam int unsigned clear_base    = 4;   // + channel, bit0 wr total, bit1 rd total
  localparam int unsigned status_base   = 8;   // + channel * stride
  localparam int unsigned status_stride = 11;

  // word index inside one channel block
  localparam int unsigned stat_wr_cmds    = 0;
  localparam int unsigned stat_wr_beats   = 1;
  localparam int unsigned stat_wr_pkts    = 2;
  localparam int unsigned stat_rd_cmds    = 3;
  localparam int unsigned stat_rd_beats   = 4;
  localparam int unsigned stat_rd_pkts    = 5;
  localparam int unsigned stat_wr_len_lo  = 6;
  localparam int unsigned stat_wr_len_hi  = 7;
  localparam int unsigned stat_rd_len_lo  = 8;
  localparam int unsigned stat_rd_len_hi  = 9;
  localparam int unsigned stat_rd_flushed = 10;

  localparam logic [reg_data_width-1:0] fpga_version = 32'h0003_0100;

endpackage

`default_nettype wire

// File: source/dma_ctrl_decoder.sv
`default_nettype none

// host write decode, scratch word and per channel clear pulses
module dma_ctrl_decoder
  import dma_pkg::*;
  import dma_regs_pkg::*;
(
  input  logic                             pcie_clk,
  input  logic                             pcie_aresetn,
  input  reg_wr_t                          reg_wr,
  output chan_clear_t [num_channels-1:0]   clear,
  output logic        [reg_data_width-1:0] scratch
);

  logic                    scratch_hit;
  logic [num_channels-1:0] clear_hit;   // one per channel clear register

  //////////////////////////////////////////////////
  // address compare
  //////////////////////////////////////////////////
  always_comb begin
    scratch_hit = reg_wr.strobe && (reg_wr.addr == reg_addr_width'(scratch_addr));
    for (int c = 0; c < num_channels; c++) begin
      clear_hit[c] = reg_wr.strobe && (reg_wr.addr == reg_addr_width'(clear_base + c));
    end
  end

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////
  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      scratch <= '0;
      clear   <= '0;
    end else begin
      if (scratch_hit) begin
        scratch <= reg_wr.data;
      end
      // pulses drop again next cycle unless rewritten
      for (int c = 0; c < num_channels; c++) begin
        clear[c].clear_wr_len <= clear_hit[c] && reg_wr.data[0];
        clear[c].clear_rd_len <= clear_hit[c] && reg_wr.data[1];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/dma_channel.sv
`default_nettype none

// one channel: command to descriptor load, plus statistics
module dma_channel
  import dma_pkg::*;
  import dma_regs_pkg::*;
(
  input  logic                                     pcie_clk,
  input  logic                                     pcie_aresetn,
  input  dma_cmd_t                                 wr_cmd,
  input  dma_cmd_t                                 rd_cmd,
  input  dma_beat_t                                c2h_beat,
  input  dma_beat_t                                h2c_beat,
  input  chan_clear_t                              clear,
  output dma_dsc_t                                 c2h_dsc,
  output dma_dsc_t                                 h2c_dsc,
  output logic [status_stride-1:0][count_width-1:0] status
);

  // direction index: 0 write (c2h), 1 read (h2c)
  dma_cmd_t  [1:0] cmd;
  dma_beat_t [1:0] beat;
  logic      [1:0] len_clr;

  logic [1:0]                  dsc_load;
  logic [1:0][addr_width-1:0]  dsc_addr;
  logic [1:0][len_width-1:0]   dsc_len;

  logic [1:0][count_width-1:0] cmd_cnt;
  logic [1:0][count_width-1:0] beat_cnt;
  logic [1:0][count_width-1:0] pkt_cnt;     // beats with last
  logic [1:0][total_width-1:0] len_total;
  logic                        rd_flushed;  // every read got its packet back

  assign cmd     = {rd_cmd, wr_cmd};
  assign beat    = {h2c_beat, c2h_beat};
  assign len_clr = {clear.clear_rd_len, clear.clear_wr_len};

  //////////////////////////////////////////////////
  // descriptor loader
  //////////////////////////////////////////////////
  always_ff @(posedge pcie_clk) begin
    for (int d = 0; d < 2; d++) begin
      if (cmd[d].valid) begin
        dsc_addr[d] <= cmd[d].addr;  // hold until next command
        dsc_len[d]  <= cmd[d].len;
      end
    end
  end

  assign c2h_dsc = '{load: dsc_load[0], addr: dsc_addr[0], len: dsc_len[0]};
  assign h2c_dsc = '{load: dsc_load[1], addr: dsc_addr[1], len: dsc_len[1]};

  //////////////////////////////////////////////////
  // statistics
  //////////////////////////////////////////////////
  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      dsc_load   <= '0;
      cmd_cnt    <= '0;
      beat_cnt   <= '0;
      pkt_cnt    <= '0;
      len_total  <= '0;
      rd_flushed <= 1'b0;
    end else begin
      for (int d = 0; d < 2; d++) begin
        dsc_load[d] <= cmd[d].valid;  // one cycle strobe, no back-pressure
        if (cmd[d].valid) begin
          cmd_cnt[d] <= cmd_cnt[d] + count_width'(1);
        end
        // clear beats a same cycle command, its length is dropped
        if (len_clr[d]) begin
          len_total[d] <= '0;
        end else if (cmd[d].valid) begin
          len_total[d] <= len_total[d] + total_width'(cmd[d].len);
        end
        if (beat[d].valid) begin
          beat_cnt[d] <= beat_cnt[d] + count_width'(1);
          if (beat[d].last) begin
            pkt_cnt[d] <= pkt_cnt[d] + count_width'(1);
          end
        end
      end
      rd_flushed <= (cmd_cnt[1] == pkt_cnt[1]);  // lags the counters by one
    end
  end

  //////////////////////////////////////////////////
  // status words
  //////////////////////////////////////////////////
  assign status[stat_wr_cmds]    = cmd_cnt[0];
  assign status[stat_wr_beats]   = beat_cnt[0];
  assign status[stat_wr_pkts]    = pkt_cnt[0];
  assign status[stat_rd_cmds]    = cmd_cnt[1];
  assign status[stat_rd_beats]   = beat_cnt[1];
  assign status[stat_rd_pkts]    = pkt_cnt[1];
  assign status[stat_wr_len_lo]  = len_total[0][count_width-1:0];
  assign status[stat_wr_len_hi]  = count_width'(len_total[0][total_width-1:count_width]);
  assign status[stat_rd_len_lo]  = len_total[1][count_width-1:0];
  assign status[stat_rd_len_hi]  = count_width'(len_total[1][total_width-1:count_width]);
  assign status[stat_rd_flushed] = count_width'(rd_flushed);

endmodule

`default_nettype wire

// File: source/dma_status_mux.sv
`default_nettype none

// host read port over version, scratch and channel status words
module dma_status_mux
  import dma_pkg::*;
  import dma_regs_pkg::*;
(
  input  logic                                                   pcie_clk,
  input  logic                                                   pcie_aresetn,
  input  reg_rd_t                                                reg_rd,
  input  logic [reg_data_width-1:0]                              scratch,
  input  logic [num_channels*status_stride-1:0][count_width-1:0] status,
  output logic [reg_data_width-1:0]                              reg_rd_data,
  output logic                                                   reg_rd_valid
);

  logic [reg_data_width-1:0] rd_word;  // decoded, before the output register

  //////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////
  always_comb begin
    rd_word = '0;  // unmapped reads return zero
    if (reg_rd.addr == reg_addr_width'(version_addr)) begin
      rd_word = fpga_version;
    end else if (reg_rd.addr == reg_addr_width'(scratch_addr)) begin
      rd_word = scratch;
    end else begin
      // channel blocks sit back to back from status_base
      for (int w = 0; w < num_channels * status_stride; w++) begin
        if (reg_rd.addr == reg_addr_width'(status_base + w)) begin
          rd_word = status[w];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // one cycle read latency
  //////////////////////////////////////////////////
  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      reg_rd_valid <= 1'b0;
    end else begin
      reg_rd_valid <= reg_rd.strobe;
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (reg_rd.strobe) begin
      reg_rd_data <= rd_word;  // held between reads
    end
  end

endmodule

`default_nettype wire

// File: source/dma_if_top.sv
`default_nettype none

// descriptor front end, four channels behind one register port
module dma_if_top
  import dma_pkg::*;
  import dma_regs_pkg::*;
(
  input  logic                               pcie_clk,
  input  logic                               pcie_aresetn,
  input  dma_cmd_t  [num_channels-1:0]       wr_cmd,
  input  dma_cmd_t  [num_channels-1:0]       rd_cmd,
  input  dma_beat_t [num_channels-1:0]       c2h_beat,
  input  dma_beat_t [num_channels-1:0]       h2c_beat,
  input  reg_wr_t                            reg_wr,
  input  reg_rd_t                            reg_rd,
  output dma_dsc_t  [num_channels-1:0]       c2h_dsc,
  output dma_dsc_t  [num_channels-1:0]       h2c_dsc,
  output logic      [reg_data_width-1:0]     reg_rd_data,
  output logic                               reg_rd_valid
);

  chan_clear_t [num_channels-1:0]                         chan_clear;
  logic [reg_data_width-1:0]                              scratch;
  logic [num_channels*status_stride-1:0][count_width-1:0] status_words;  // all blocks

  dma_ctrl_decoder ctrl_decoder_i (
    .pcie_clk     (pcie_clk),
    .pcie_aresetn (pcie_aresetn),
    .reg_wr       (reg_wr),
    .clear        (chan_clear),
    .scratch      (scratch)
  );

  for (genvar i = 0; i < num_channels; i++) begin : g_chan
    dma_channel channel_i (
      .pcie_clk     (pcie_clk),
      .pcie_aresetn (pcie_aresetn),
      .wr_cmd       (wr_cmd[i]),
      .rd_cmd       (rd_cmd[i]),
      .c2h_beat     (c2h_beat[i]),
      .h2c_beat     (h2c_beat[i]),
      .clear        (chan_clear[i]),
      .c2h_dsc      (c2h_dsc[i]),
      .h2c_dsc      (h2c_dsc[i]),
      .status       (status_words[i*status_stride +: status_stride])  // own block
    );
  end

  dma_status_mux status_mux_i (
    .pcie_clk     (pcie_clk),
    .pcie_aresetn (pcie_aresetn),
    .reg_rd       (reg_rd),
    .scratch      (scratch),
    .status       (status_words),
    .reg_rd_data  (reg_rd_data),
    .reg_rd_valid (reg_rd_valid)
  );

endmodule

`default_nettype wire

// File: verif/dma_if_tb.sv
`default_nettype none

module dma_if_tb
  import dma_pkg::*;
  import dma_regs_pkg::*;
();

  localparam int clk_period = 40;
  localparam logic [2:0] op_wr_cmd  = 3'd0;
  localparam logic [2:0] op_rd_cmd  = 3'd1;
  localparam logic [2:0] op_wr_pkt  = 3'd2;  // c2h beats
  localparam logic [2:0] op_rd_pkt  = 3'd3;  // h2c beats
  localparam logic [2:0] op_clear   = 3'd4;  // val is the clear mask
  localparam logic [2:0] op_scratch = 3'd5;  // val is the scratch data

  typedef struct packed {
    logic [1:0]  chan;
    logic [2:0]  op;
    logic [31:0] val;    // length, mask or data
    logic [3:0]  beats;
  } row_t;

  //////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////
  localparam int num_rows       = 22;
  localparam int timeout_cycles = num_rows * 64;
  localparam row_t stim [num_rows] = '{
    '{2'd0, op_wr_cmd,  32'h0000_0100, 4'd0},
    '{2'd0, op_wr_pkt,  32'h0,         4'd4},
    '{2'd0, op_rd_cmd,  32'h0000_0200, 4'd0},
    '{2'd0, op_rd_pkt,  32'h0,         4'd2},
    '{2'd1, op_wr_cmd,  32'hf000_0000, 4'd0},  // wr total passes 32 bits
    '{2'd1, op_wr_cmd,  32'hf000_0000, 4'd0},
    '{2'd1, op_wr_cmd,  32'hffff_ffff, 4'd0},
    '{2'd1, op_rd_cmd,  32'h8000_0000, 4'd0},
    '{2'd1, op_clear,   32'h2,         4'd0},  // rd total only
    '{2'd1, op_rd_cmd,  32'h0000_0040, 4'd0},
    '{2'd2, op_rd_cmd,  32'h0000_1000, 4'd0},
    '{2'd2, op_rd_cmd,  32'h0000_2000, 4'd0},
    '{2'd2, op_rd_pkt,  32'h0,         4'd1},
    '{2'd0, op_scratch, 32'ha5a5_0001, 4'd0},
    '{2'd2, op_clear,   32'h3,         4'd0},
    '{2'd2, op_rd_cmd,  32'h0000_0030, 4'd0},
    '{2'd3, op_rd_cmd,  32'hffff_ffff, 4'd0},
    '{2'd3, op_rd_cmd,  32'hffff_ffff, 4'd0},
    '{2'd3, op_rd_pkt,  32'h0,         4'd3},
    '{2'd3, op_rd_pkt,  32'h0,         4'd1},
    '{2'd3, op_wr_cmd,  32'h0000_0010, 4'd0},
    '{2'd3, op_wr_pkt,  32'h0,         4'd5}
  };

  logic                           pcie_clk;
  logic                           pcie_aresetn;
  dma_cmd_t  [num_channels-1:0]   wr_cmd;
  dma_cmd_t  [num_channels-1:0]   rd_cmd;
  dma_beat_t [num_channels-1:0]   c2h_beat;
  dma_beat_t [num_channels-1:0]   h2c_beat;
  reg_wr_t                        reg_wr;
  reg_rd_t                        reg_rd;
  dma_dsc_t  [num_channels-1:0]   c2h_dsc;
  dma_dsc_t  [num_channels-1:0]   h2c_dsc;
  logic      [reg_data_width-1:0] reg_rd_data;
  logic                           reg_rd_valid;
  integer                         seed = 76;

  // reference model, second index 0 write, 1 read
  logic [count_width-1:0]    exp_cmds  [num_channels][2];
  logic [count_width-1:0]    exp_beats [num_channels][2];
  logic [count_width-1:0]    exp_pkts  [num_channels][2];
  logic [total_width-1:0]    exp_total [num_channels][2];
  logic [reg_data_width-1:0] exp_scratch;

  dma_if_top dut_i (
    .pcie_clk     (pcie_clk),
    .pcie_aresetn (pcie_aresetn),
    .wr_cmd       (wr_cmd),
    .rd_cmd       (rd_cmd),
    .c2h_beat     (c2h_beat),
    .h2c_beat     (h2c_beat),
    .reg_wr       (reg_wr),
    .reg_rd       (reg_rd),
    .c2h_dsc      (c2h_dsc),
    .h2c_dsc      (h2c_dsc),
    .reg_rd_data  (reg_rd_data),
    .reg_rd_valid (reg_rd_valid)
  );

  always #(clk_period / 2) pcie_clk = ~pcie_clk;

  initial begin
    #(timeout_cycles * clk_period);
    $display("watchdog expired, run did not finish within %0d cycles", timeout_cycles);
    $display("TESTBENCH FAILED");
    $fatal(1, "timeout");
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////
  task automatic check(input string name, input logic [63:0] actual,
                       input logic [63:0] expected);
    if (actual !== expected) begin
      $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic dma_dsc_t dsc_of(input int ch, input bit rd);
    if (rd) begin
      return h2c_dsc[ch];
    end else begin
      return c2h_dsc[ch];
    end
  endfunction

  // command strobe, then the load one cycle later and gone after that
  task automatic send_cmd(input int ch, input bit rd, input logic [len_width-1:0] len);
    dma_cmd_t cmd;
    dma_dsc_t dsc;
    string    pfx;
    pfx       = $sformatf("%s_dsc[%0d]", rd ? "h2c" : "c2h", ch);
    cmd.valid = 1'b1;
    cmd.addr  = {$random(seed), $random(seed)};
    cmd.len   = len;
    if (rd) rd_cmd[ch] = cmd;
    else    wr_cmd[ch] = cmd;
    dsc = dsc_of(ch, rd);
    check({pfx, ".load"}, 64'(dsc.load), 64'(0));
    @(negedge pcie_clk);
    rd_cmd[ch] = '0;
    wr_cmd[ch] = '0;
    dsc = dsc_of(ch, rd);
    check({pfx, ".load"}, 64'(dsc.load), 64'(1));
    check({pfx, ".addr"}, dsc.addr, cmd.addr);
    check({pfx, ".len"}, 64'(dsc.len), 64'(len));
    @(negedge pcie_clk);
    dsc = dsc_of(ch, rd);
    check({pfx, ".load"}, 64'(dsc.load), 64'(0));
    exp_cmds[ch][rd]  = exp_cmds[ch][rd] + count_width'(1);
    exp_total[ch][rd] = exp_total[ch][rd] + total_width'(len);
  endtask

  task automatic send_pkt(input int ch, input bit rd, input int beats);
    dma_beat_t bt;
    for (int b = 0; b < beats; b++) begin
      bt.valid = 1'b1;
      bt.last  = (b == beats - 1);  // last beat closes the packet
      if (rd) h2c_beat[ch] = bt;
      else    c2h_beat[ch] = bt;
      @(negedge pcie_clk);
    end
    h2c_beat[ch] = '0;
    c2h_beat[ch] = '0;
    exp_beats[ch][rd] = exp_beats[ch][rd] + count_width'(beats);
    exp_pkts[ch][rd]  = exp_pkts[ch][rd] + count_width'(1);
  endtask

  task automatic reg_write(input logic [reg_addr_width-1:0] addr,
                           input logic [reg_data_width-1:0] data);
    reg_wr = '{strobe: 1'b1, addr: addr, data: data};
    @(negedge pcie_clk);
    reg_wr = '0;
  endtask

  // valid must rise exactly one cycle after the strobe
  task automatic reg_read_check(input logic [reg_addr_width-1:0] addr,
                                input logic [reg_data_width-1:0] expected, input string name);
    reg_rd = '{strobe: 1'b1, addr: addr};
    check("reg_rd_valid", 64'(reg_rd_valid), 64'(0));
    @(negedge pcie_clk);
    reg_rd = '0;
    check("reg_rd_valid", 64'(reg_rd_valid), 64'(1));
    check({"reg_rd_data ", name}, 64'(reg_rd_data), 64'(expected));
    @(negedge pcie_clk);
    check("reg_rd_valid", 64'(reg_rd_valid), 64'(0));
  endtask

  function automatic logic [count_width-1:0] expected_word(input int ch, input int idx);
    case (idx)
      stat_wr_cmds:   return exp_cmds[ch][0];
      stat_wr_beats:  return exp_beats[ch][0];
      stat_wr_pkts:   return exp_pkts[ch][0];
      stat_rd_cmds:   return exp_cmds[ch][1];
      stat_rd_beats:  return exp_beats[ch][1];
      stat_rd_pkts:   return exp_pkts[ch][1];
      stat_wr_len_lo: return exp_total[ch][0][count_width-1:0];
      stat_wr_len_hi: return count_width'(exp_total[ch][0][total_width-1:count_width]);
      stat_rd_len_lo: return exp_total[ch][1][count_width-1:0];
      stat_rd_len_hi: return count_width'(exp_total[ch][1][total_width-1:count_width]);
      default:        return (exp_cmds[ch][1] == exp_pkts[ch][1]) ? 32'd1 : 32'd0;  // flushed
    endcase
  endfunction

  task automatic check_all_status();
    for (int ch = 0; ch < num_channels; ch++) begin
      for (int idx = 0; idx < status_stride; idx++) begin
        reg_read_check(reg_addr_width'(status_base + ch * status_stride + idx),
                       expected_word(ch, idx), $sformatf("ch%0d word %0d", ch, idx));
      end
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin
    row_t row;
    int   ch;
    pcie_clk     = 1'b0;
    pcie_aresetn = 1'b0;
    wr_cmd       = '0;
    rd_cmd       = '0;
    c2h_beat     = '0;
    h2c_beat     = '0;
    reg_wr       = '0;
    reg_rd       = '0;
    exp_scratch  = '0;
    for (int c = 0; c < num_channels; c++) begin
      for (int d = 0; d < 2; d++) begin
        exp_cmds[c][d]  = '0;
        exp_beats[c][d] = '0;
        exp_pkts[c][d]  = '0;
        exp_total[c][d] = '0;
      end
    end
    repeat (8) @(posedge pcie_clk);
    @(negedge pcie_clk);
    pcie_aresetn = 1'b1;
    repeat (4) @(negedge pcie_clk);  // flushed flag settles

    for (int c = 0; c < num_channels; c++) begin
      check($sformatf("c2h_dsc[%0d].load", c), 64'(c2h_dsc[c].load), 64'(0));
      check($sformatf("h2c_dsc[%0d].load", c), 64'(h2c_dsc[c].load), 64'(0));
    end
    reg_read_check(reg_addr_width'(version_addr), fpga_version, "version");
    check_all_status();

    for (int i = 0; i < num_rows; i++) begin
      row = stim[i];
      ch  = int'(row.chan);
      case (row.op)
        op_wr_cmd: send_cmd(ch, 1'b0, row.val);
        op_rd_cmd: send_cmd(ch, 1'b1, row.val);
        op_wr_pkt: send_pkt(ch, 1'b0, int'(row.beats));
        op_rd_pkt: send_pkt(ch, 1'b1, int'(row.beats));
        op_clear: begin
          reg_write(reg_addr_width'(clear_base + ch), row.val);
          if (row.val[0]) exp_total[ch][0] = '0;
          if (row.val[1]) exp_total[ch][1] = '0;
        end
        op_scratch: begin
          reg_write(reg_addr_width'(scratch_addr), row.val);
          exp_scratch = row.val;
          reg_read_check(reg_addr_width'(scratch_addr), exp_scratch, "scratch");
        end
        default: begin
        end
      endcase
      @(negedge pcie_clk);  // gap keeps a clear pulse off the next command
    end

    repeat (4) @(negedge pcie_clk);
    check_all_status();
    reg_read_check(reg_addr_width'(scratch_addr), exp_scratch, "scratch");
    reg_read_check(9'd2, '0, "unmapped word 2");
    reg_read_check(reg_addr_width'(status_base + num_channels * status_stride), '0,
                   "unmapped word past last block");
    reg_read_check(9'h1ff, '0, "unmapped top word");
    reg_read_check(reg_addr_width'(version_addr), fpga_version, "version");
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: dma_if.f
source/dma_pkg.sv
source/dma_regs_pkg.sv
source/dma_ctrl_decoder.sv
source/dma_channel.sv
source/dma_status_mux.sv
source/dma_if_top.sv
verif/dma_if_tb.sv

// File: Makefile
TB_TOP := dma_if_tb

.PHONY: all lint sim clean

all: sim

# rtl only, testbench is not linted
lint:
	verilator --lint-only -Wall --top-module dma_if_top \
		source/dma_pkg.sv source/dma_regs_pkg.sv source/dma_ctrl_decoder.sv \
		source/dma_channel.sv source/dma_status_mux.sv source/dma_if_top.sv

sim:
	verilator --binary --timing --top-module $(TB_TOP) -f dma_if.f -Mdir obj_dir -o $(TB_TOP)
	./obj_dir/$(TB_TOP) 2>&1 | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
